// File: hw/async_sram_ctrl.sv
`timescale 1ns/1ps

module async_sram_ctrl
    import sram_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req,
    input  logic       we,
    input  word_addr_t addr,
    input  word_t      wdata,
    input  mem_data_t  mem_rdata,
    output logic       busy,
    output logic       done,
    output word_t      rdata,
    output byte_addr_t mem_addr,
    output mem_data_t  mem_wdata,
    output mem_data_t  mem_oe_t,
    output logic       mem_nce,
    output logic       mem_noe,
    output logic       mem_nwe
);

    ctrl_state_t state;
    wait_cnt_t   wait_cnt;
    // Low byte first, then high byte
    logic        byte_sel;

    // Latched request
    logic        op_we;
    word_addr_t  addr_q;
    word_t       wdata_q;

    // Low byte of a read kept until the high byte arrives
    mem_data_t   rd_lo;
    word_t       rdata_q;

    logic        strobe_last;
    logic        active;
    logic        done_pre;
    logic        cap_pre;
    // Delayed by one cycle to line up with the PHY registers
    logic        done_q;
    logic        cap_q;
    logic        cap_hi_q;

    assign strobe_last = (wait_cnt == WAIT_CNT_W'(WAIT_CYCLES - 1));
    assign active      = (state != IDLE);

    // End of the high byte HOLD phase closes the word access
    assign done_pre = (state == HOLD) && byte_sel;
    // Last strobe cycle of a read
    assign cap_pre  = (state == STROBE) && strobe_last && !op_we;

    // Main FSM
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= IDLE;
            wait_cnt <= '0;
            byte_sel <= 1'b0;
            op_we    <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req)
                    begin
                        state    <= SETUP;
                        byte_sel <= 1'b0;
                        op_we    <= we;
                    end
                end
                SETUP:
                begin
                    // Address settles before the strobe
                    state    <= STROBE;
                    wait_cnt <= '0;
                end
                STROBE:
                begin
                    if (strobe_last)
                    begin
                        state <= HOLD;
                    end
                    else
                    begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                HOLD:
                begin
                    if (byte_sel)
                    begin
                        state <= IDLE;
                    end
                    else
                    begin
                        // Second pass for the high byte
                        state    <= SETUP;
                        byte_sel <= 1'b1;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Address and write data of the accepted request
    always_ff @(posedge clk)
    begin
        if (req && !active)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    // done and the read capture strobe one cycle behind the FSM
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            done_q   <= 1'b0;
            cap_q    <= 1'b0;
            cap_hi_q <= 1'b0;
        end
        else
        begin
            done_q   <= done_pre;
            cap_q    <= cap_pre;
            cap_hi_q <= byte_sel;
        end
    end

    // Read assembly
    // rdata changes together with done and holds until the next read
    always_ff @(posedge clk)
    begin
        if (cap_q)
        begin
            if (cap_hi_q)
            begin
                rdata_q <= {mem_rdata, rd_lo};
            end
            else
            begin
                rd_lo <= mem_rdata;
            end
        end
    end

    assign busy  = active;
    assign done  = done_q;
    assign rdata = rdata_q;

    // Byte address is the word address with the byte select appended
    assign mem_addr  = {addr_q, byte_sel};
    assign mem_wdata = byte_sel ? wdata_q[WORD_W-1:MEM_W] : wdata_q[MEM_W-1:0];

    // Chip enabled for the whole access
    assign mem_nce  = !active;
    // Strobes only in STROBE with noe for reads and nwe for writes
    assign mem_noe  = !((state == STROBE) && !op_we);
    assign mem_nwe  = !((state == STROBE) && op_we);
    // Writes drive the bus through SETUP, STROBE and HOLD so data
    // covers the rising edge of nwe at the pins
    assign mem_oe_t = (active && op_we) ? '0 : '1;

    // Protocol checks
    a_no_req_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
        req |-> !busy)
        else $error("req issued while busy");

    // Strobes never overlap and never hand over directly from one to the other
    // The operation type has to stay fixed for the whole access
    a_no_oe_we_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_noe || (mem_nwe && $past(mem_nwe))) && (mem_nwe || $past(mem_noe)))
        else $error("noe and nwe low together");

    a_done_single: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done longer than one cycle");

endmodule

// File: hw/async_sram_phy.sv
`timescale 1ns/1ps

module async_sram_phy
    import sram_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  byte_addr_t     mem_addr,
    input  mem_data_t      mem_wdata,
    input  mem_data_t      mem_oe_t,
    input  logic           mem_nce,
    input  logic           mem_noe,
    input  logic           mem_nwe,
    output mem_data_t      mem_rdata,
    output byte_addr_t     sram_addr,
    output logic           sram_nce,
    output logic           sram_noe,
    output logic           sram_nwe,
    inout  wire mem_data_t sram_data
);

    // Output data and tristate enables, one flop per pin
    mem_data_t wdata_q;
    mem_data_t oe_t_q;

    // Control pins and bus enables come out of reset in the idle state
    // Chip deselected, no strobes, bus released
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sram_nce <= 1'b1;
            sram_noe <= 1'b1;
            sram_nwe <= 1'b1;
            oe_t_q   <= '1;
        end
        else
        begin
            sram_nce <= mem_nce;
            sram_noe <= mem_noe;
            sram_nwe <= mem_nwe;
            oe_t_q   <= mem_oe_t;
        end
    end

    // Address and data path registers
    always_ff @(posedge clk)
    begin
        sram_addr <= mem_addr;
        wdata_q   <= mem_wdata;
        // Input register on the pins
        mem_rdata <= sram_data;
    end

    // Per-bit tristate buffer
    // High enable releases the pin
    for (genvar i = 0; i < MEM_W; i++)
    begin : g_data_buf
        assign sram_data[i] = oe_t_q[i] ? 1'bz : wdata_q[i];
    end

    // Bus contention on the pins: we drive while the chip drives
    a_no_drive_on_read: assert property (@(posedge clk) disable iff (!arst_n)
        !sram_noe |-> (&oe_t_q))
        else $error("SRAM data bus driven while output enable is low");

endmodule

// File: hw/sram_pkg.sv
package sram_pkg;

    // User word address and the byte address on the SRAM pins
    localparam int WORD_ADDR_W = 20;
    // One extra bit on the pins selects the byte within a word
    localparam int BYTE_ADDR_W = WORD_ADDR_W + 1;

    // User word and external SRAM data widths
    localparam int WORD_W = 16;
    localparam int MEM_W  = 8;

    // Cycles the strobe stays low in each byte access
    localparam int WAIT_CYCLES = 2;
    // Wide enough to hold any count up to WAIT_CYCLES
    localparam int WAIT_CNT_W  = $clog2(WAIT_CYCLES + 1);

    // User side word address
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    // Pin address, bit 0 is the byte select
    typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
    // User data word
    typedef logic [WORD_W-1:0]      word_t;
    // One SRAM byte, also used for the per-bit tristate enables
    typedef logic [MEM_W-1:0]       mem_data_t;
    // Strobe wait counter
    typedef logic [WAIT_CNT_W-1:0]  wait_cnt_t;

    // Controller FSM
    // Every byte access walks SETUP, STROBE and HOLD
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        STROBE,
        HOLD
    } ctrl_state_t;

endpackage

// File: hw/sram_subsystem_top.sv
`timescale 1ns/1ps

module sram_subsystem_top
    import sram_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           req,
    input  logic           we,
    input  word_addr_t     addr,
    input  word_t          wdata,
    output logic           busy,
    output logic           done,
    output word_t          rdata,
    output byte_addr_t     sram_addr,
    inout  wire mem_data_t sram_data,
    output logic           sram_nce,
    output logic           sram_noe,
    output logic           sram_nwe
);

    // Controller to PHY
    byte_addr_t mem_addr;
    mem_data_t  mem_wdata;
    mem_data_t  mem_oe_t;
    logic       mem_nce;
    logic       mem_noe;
    logic       mem_nwe;
    // PHY to controller, pins registered once
    mem_data_t  mem_rdata;

    async_sram_ctrl ctrl_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .mem_rdata (mem_rdata),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_oe_t  (mem_oe_t),
        .mem_nce   (mem_nce),
        .mem_noe   (mem_noe),
        .mem_nwe   (mem_nwe)
    );

    async_sram_phy phy_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_oe_t  (mem_oe_t),
        .mem_nce   (mem_nce),
        .mem_noe   (mem_noe),
        .mem_nwe   (mem_nwe),
        .mem_rdata (mem_rdata),
        .sram_addr (sram_addr),
        .sram_nce  (sram_nce),
        .sram_noe  (sram_noe),
        .sram_nwe  (sram_nwe),
        .sram_data (sram_data)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SRAM subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_sram_subsystem -f sources.f -o tb_sram_subsystem
./obj_dir/tb_sram_subsystem

// File: sources.f
hw/sram_pkg.sv
hw/async_sram_phy.sv
hw/async_sram_ctrl.sv
hw/sram_subsystem_top.sv
verification/sram_chip_model.sv
verification/tb_sram_subsystem.sv

// File: verification/sram_chip_model.sv
`timescale 1ns/1ps

module sram_chip_model
    import sram_pkg::*;
(
    input  byte_addr_t     addr,
    inout  wire mem_data_t data,
    input  logic           nce,
    input  logic           noe,
    input  logic           nwe
);

    // One byte per pin address, the whole 21-bit space
    localparam int DEPTH = 1 << BYTE_ADDR_W;

    mem_data_t mem [DEPTH];

    // Blank chip reads as zero
    initial
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            mem[i] = '0;
        end
    end

    // Chip drives the bus only while selected for a read
    assign data = (!nce && !noe && nwe) ? mem[addr] : 'z;

    // Asynchronous write, data taken on the rising edge of nwe
    always @(posedge nwe)
    begin
        if (!nce)
        begin
            mem[addr] <= data;
        end
    end

endmodule

// File: verification/tb_sram_subsystem.sv
`timescale 1ns/1ps

module tb_sram_subsystem
    import sram_pkg::*;
();

    localparam int SEED         = 30;
    // Edges from the one that samples req to the one that sees done
    localparam int DONE_LATENCY = 9;
    localparam int DONE_TIMEOUT = 40;
    localparam int READBACK_OPS = 16;
    localparam int MIX_OPS      = 200;
    localparam int WINDOW_WORDS = 64;

    logic           clk;
    logic           arst_n;
    logic           req;
    logic           we;
    word_addr_t     addr;
    word_t          wdata;
    logic           busy;
    logic           done;
    word_t          rdata;
    byte_addr_t     sram_addr;
    wire mem_data_t sram_data;
    logic           sram_nce;
    logic           sram_noe;
    logic           sram_nwe;

    // Reference memory, unwritten words read as zero
    word_t          model_mem [word_addr_t];
    word_addr_t     written_q [$];

    sram_subsystem_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .sram_addr (sram_addr),
        .sram_data (sram_data),
        .sram_nce  (sram_nce),
        .sram_noe  (sram_noe),
        .sram_nwe  (sram_nwe)
    );

    sram_chip_model chip_i (
        .addr (sram_addr),
        .data (sram_data),
        .nce  (sram_nce),
        .noe  (sram_noe),
        .nwe  (sram_nwe)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t model_read(input word_addr_t a);
        if (model_mem.exists(a))
        begin
            return model_mem[a];
        end
        return '0;
    endfunction

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s, got %b, expected %b", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "flag compare failed");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, DONE_TIMEOUT);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on timeout");
    endtask

    // One word access, checked for latency, pin bytes and read data
    task automatic run_access(input logic wr, input word_addr_t a, input word_t d);
        int        cycles;
        logic      got_done;
        mem_data_t pin_lo;
        mem_data_t pin_hi;
        word_t     expected;
        @(posedge clk);
        #2;
        // Previous done must already be gone
        check_flag(done, 1'b0, "done pulse width");
        check_flag(busy, 1'b0, "busy before request");
        req   = 1'b1;
        we    = wr;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #2;
        req   = 1'b0;
        // Request is latched, so scramble the inputs
        we    = 1'(($urandom) & 1);
        addr  = word_addr_t'($urandom);
        wdata = word_t'($urandom);
        expected = wr ? d : model_read(a);
        cycles   = 0;
        got_done = 1'b0;
        pin_lo   = '0;
        pin_hi   = '0;
        while (!got_done)
        begin
            @(negedge clk);
            cycles++;
            if (done)
            begin
                got_done = 1'b1;
            end
            else if (cycles >= DONE_TIMEOUT)
            begin
                stop_on_timeout("done");
            end
            else
            begin
                check_flag(busy, 1'b1, "busy during access");
            end
            // Bytes on the pins while a strobe is low
            if (!sram_noe || !sram_nwe)
            begin
                check_flag(sram_nce, 1'b0, "chip enable during strobe");
                check_flag(logic'(sram_addr[BYTE_ADDR_W-1:1] == a), 1'b1, "pin word address");
                if (sram_addr[0])
                begin
                    pin_hi = sram_data;
                end
                else
                begin
                    pin_lo = sram_data;
                end
            end
        end
        check_flag(logic'(cycles == DONE_LATENCY), 1'b1, "done latency");
        check_flag(busy, 1'b0, "busy at done");
        // Low byte at the even pin address, high byte at the odd one
        check_word({pin_hi, pin_lo}, expected, "byte order on pins");
        if (wr)
        begin
            model_mem[a] = d;
        end
        else
        begin
            check_word(rdata, expected, "read data");
        end
    endtask

    initial
    begin
        word_addr_t a;
        word_t      d;
        word_addr_t window_base;
        void'($urandom(SEED));
        arst_n = 1'b0;
        req    = 1'b0;
        we     = 1'b0;
        addr   = '0;
        wdata  = '0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Idle outputs until the first request
        repeat (4)
        begin
            @(negedge clk);
            check_flag(busy, 1'b0, "busy after reset");
            check_flag(done, 1'b0, "done after reset");
            check_flag(sram_nce, 1'b1, "sram_nce after reset");
            check_flag(sram_noe, 1'b1, "sram_noe after reset");
            check_flag(sram_nwe, 1'b1, "sram_nwe after reset");
        end

        // Distinct bytes make a swap visible
        run_access(1'b1, 20'h12345, 16'hA55A);
        run_access(1'b0, 20'h12345, '0);

        // Write then read back across the full address range
        repeat (READBACK_OPS)
        begin
            a = word_addr_t'($urandom);
            d = word_t'($urandom);
            run_access(1'b1, a, d);
            written_q.push_back(a);
        end
        foreach (written_q[i])
        begin
            run_access(1'b0, written_q[i], '0);
        end

        // Mixed traffic in a small window, many reads hit blank words
        window_base = word_addr_t'($urandom) & ~word_addr_t'(WINDOW_WORDS - 1);
        repeat (MIX_OPS)
        begin
            a = window_base + word_addr_t'($urandom_range(WINDOW_WORDS - 1));
            d = word_t'($urandom);
            run_access(1'($urandom_range(1)), a, d);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule
